// ==== riscvControlPkg.sv ====
package riscvControlPkg;
        localparam int xlen = 64; // Datapath width
        localparam int instrWidth = 32; // Instruction register width

        localparam logic [6:0] opR = 7'b0110011; // Register-register ALU ops
        localparam logic [6:0] opImm = 7'b0010011; // Register-immediate ALU ops
        localparam logic [6:0] opLoad = 7'b0000011;
        localparam logic [6:0] opStore = 7'b0100011;
        localparam logic [6:0] opBranch = 7'b1100011; // All conditional branches
        localparam logic [6:0] opLui = 7'b0110111;
        localparam logic [6:0] opJal = 7'b1101111;
        localparam logic [6:0] opJalr = 7'b1100111;
        localparam logic [6:0] opSystem = 7'b1110011; // Break lives here

        localparam logic [2:0] f3Add = 3'b000; // Shared by add and sub
        localparam logic [2:0] f3And = 3'b111;
        localparam logic [2:0] f3Slt = 3'b010;
        localparam logic [2:0] f3Addi = 3'b000;
        localparam logic [2:0] f3Slti = 3'b010;
        localparam logic [2:0] f3Ld = 3'b011; // Doubleword
        localparam logic [2:0] f3Sd = 3'b011; // Doubleword
        localparam logic [2:0] f3Beq = 3'b000;
        localparam logic [2:0] f3Bne = 3'b001;
        localparam logic [2:0] f3Blt = 3'b100;
        localparam logic [2:0] f3Bge = 3'b101;
        localparam logic [2:0] f3Jalr = 3'b000;
        localparam logic [2:0] f3Break = 3'b000;
        localparam logic [6:0] f7Base = 7'b0000000; // add, and, slt
        localparam logic [6:0] f7Sub = 7'b0100000;

        localparam logic [instrWidth-1:0] nopWord = 32'h0000_0013; // addi x0, x0, 0

        typedef enum logic [2:0] {aluAdd = 3'd1, aluSub = 3'd2, aluAnd = 3'd3,
                aluCompare = 3'd7} aluFctT;
        typedef enum logic [1:0] {srcAPc = 2'd0, srcARegA = 2'd1, srcAZero = 2'd2} aluSrcAT;
        typedef enum logic [2:0] {srcBRegB = 3'd0, srcBFour = 3'd1, srcBImm = 3'd2,
                srcBZero = 3'd3, srcBOne = 3'd4} aluSrcBT;
        typedef enum logic {fromMem = 1'b0, fromAluOut = 1'b1} memToRegT;
        typedef enum logic [2:0] {immI = 3'd0, immS = 3'd1, immSb = 3'd2, immUj = 3'd3,
                immU = 3'd4} immTypeT;

        typedef enum logic [4:0] {opkAdd, opkSub, opkAnd, opkSlt, opkAddi, opkSlti, opkNop,
                opkLd, opkSd, opkBeq, opkBne, opkBge, opkBlt, opkLui, opkJal, opkJalr,
                opkBreak, opkIllegal} opKindT;

        // ALU and jump states split per operation so the word table needs only the state
        typedef enum logic [4:0] {stReset, stFetch, stSaveInstr, stDecode, stAluAdd, stAluSub,
                stAluAnd, stAluImm, stSetCompare, stSetCompareImm, stSetLess, stWriteAlu,
                stMemAddr, stMemRead, stMdrLoad, stWriteMem, stStore, stBranch, stBranchTake,
                stLui, stLinkSave, stLinkWrite, stJumpPc, stJumpReg, stHalt, stTrap} stateT;

        typedef struct packed {
                logic equal; // rs1 == rs2
                logic lessThan; // Signed rs1 < operand B
        } aluFlagsT;

        typedef struct packed {
                logic loadIr;
                logic pcWrite;
                logic regWrite; // Register file write port
                logic loadRegA;
                logic loadRegB;
                logic loadMdr;
                logic loadAluOut;
                logic memWrite; // Data memory write, read otherwise
                memToRegT memToReg;
                aluSrcAT aluSrcA;
                aluSrcBT aluSrcB;
                aluFctT aluFct;
        } tableWordT;

        typedef struct packed {
                logic loadIr;
                logic pcWrite;
                logic regWrite;
                logic loadRegA;
                logic loadRegB;
                logic loadMdr;
                logic loadAluOut;
                logic memWrite;
                memToRegT memToReg;
                aluSrcAT aluSrcA;
                aluSrcBT aluSrcB;
                aluFctT aluFct;
                immTypeT immType; // Sign extender format, straight from decode
        } controlWordT;

        typedef struct packed {
                logic halted; // Break or trap reached
                logic illegal; // Trap only
        } unitStatusT;

        localparam tableWordT idleWord = '{loadIr: 1'b0, pcWrite: 1'b0, regWrite: 1'b0,
                loadRegA: 1'b0, loadRegB: 1'b0, loadMdr: 1'b0, loadAluOut: 1'b0,
                memWrite: 1'b0, memToReg: fromMem, aluSrcA: srcAPc, aluSrcB: srcBRegB,
                aluFct: aluAdd};
endpackage

// ==== instrDecoder.sv ====
module instrDecoder import riscvControlPkg::*; (
        input logic [instrWidth-1:0] instr, // Held in the instruction register
        output opKindT opKind,
        output immTypeT immType
);
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;

        assign opcode = instr[6:0];
        assign funct3 = instr[14:12];
        assign funct7 = instr[31:25];

        always_comb begin
                opKind = opkIllegal; // Anything unmatched traps
                immType = immI;
                case (opcode)
                        opR: begin
                                case ({funct7, funct3})
                                        {f7Base, f3Add}: opKind = opkAdd;
                                        {f7Sub, f3Add}: opKind = opkSub;
                                        {f7Base, f3And}: opKind = opkAnd;
                                        {f7Base, f3Slt}: opKind = opkSlt;
                                        default: opKind = opkIllegal; // Unknown funct7 or funct3
                                endcase
                        end
                        opImm: begin
                                if (instr == nopWord) begin
                                        opKind = opkNop; // Only the canonical encoding
                                end else if (funct3 == f3Addi) begin
                                        opKind = opkAddi;
                                end else if (funct3 == f3Slti) begin
                                        opKind = opkSlti;
                                end
                        end
                        opLoad: begin
                                if (funct3 == f3Ld) opKind = opkLd;
                        end
                        opStore: begin
                                immType = immS; // Split offset
                                if (funct3 == f3Sd) opKind = opkSd;
                        end
                        opBranch: begin
                                immType = immSb;
                                case (funct3)
                                        f3Beq: opKind = opkBeq;
                                        f3Bne: opKind = opkBne;
                                        f3Blt: opKind = opkBlt;
                                        f3Bge: opKind = opkBge;
                                        default: opKind = opkIllegal;
                                endcase
                        end
                        opLui: begin
                                immType = immU; // Upper 20 bits
                                opKind = opkLui;
                        end
                        opJal: begin
                                immType = immUj;
                                opKind = opkJal;
                        end
                        opJalr: begin
                                if (funct3 == f3Jalr) opKind = opkJalr; // I format offset
                        end
                        opSystem: begin
                                if (instr[31:7] == {12'h001, 5'd0, f3Break, 5'd0}) begin
                                        opKind = opkBreak; // Exact ebreak word
                                end
                        end
                        default: opKind = opkIllegal; // Unknown major opcode
                endcase
        end
endmodule

// ==== controlSequencer.sv ====
module controlSequencer import riscvControlPkg::*; (
        input logic clock,
        input logic reset,
        input opKindT opKind, // Stable from decode until next fetch
        input aluFlagsT flags,
        output stateT state,
        output unitStatusT status
);
        stateT nextState;
        logic takeBranch;

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        state <= stReset;
                end else begin
                        state <= nextState;
                end
        end

        // Branch condition per kind, flags valid during stBranch
        always_comb begin
                case (opKind)
                        opkBeq: takeBranch = flags.equal;
                        opkBne: takeBranch = !flags.equal;
                        opkBlt: takeBranch = flags.lessThan;
                        opkBge: takeBranch = !flags.lessThan;
                        default: takeBranch = 1'b0;
                endcase
        end

        always_comb begin
                nextState = stTrap; // Unused encodings land in the trap
                case (state)
                        stReset: nextState = stFetch;
                        stFetch: nextState = stSaveInstr;
                        stSaveInstr: nextState = stDecode;
                        stDecode: begin
                                case (opKind)
                                        opkAdd: nextState = stAluAdd;
                                        opkSub: nextState = stAluSub;
                                        opkAnd: nextState = stAluAnd;
                                        opkAddi: nextState = stAluImm;
                                        opkSlt: nextState = stSetCompare;
                                        opkSlti: nextState = stSetCompareImm;
                                        opkNop: nextState = stFetch; // Nothing to execute
                                        opkLd, opkSd: nextState = stMemAddr;
                                        opkBeq, opkBne, opkBge, opkBlt: nextState = stBranch;
                                        opkLui: nextState = stLui;
                                        opkJal, opkJalr: nextState = stLinkSave;
                                        opkBreak: nextState = stHalt;
                                        default: nextState = stTrap;
                                endcase
                        end
                        stAluAdd, stAluSub, stAluAnd, stAluImm, stLui: nextState = stWriteAlu;
                        stSetCompare, stSetCompareImm: nextState = stSetLess;
                        stSetLess: nextState = stWriteAlu;
                        stMemAddr: nextState = (opKind == opkLd) ? stMemRead : stStore;
                        stMemRead: nextState = stMdrLoad;
                        stMdrLoad: nextState = stWriteMem;
                        stBranch: nextState = takeBranch ? stBranchTake : stFetch;
                        stLinkSave: nextState = stLinkWrite;
                        stLinkWrite: nextState = (opKind == opkJalr) ? stJumpReg : stJumpPc;
                        stWriteAlu, stWriteMem, stStore, stBranchTake, stJumpPc,
                                stJumpReg: nextState = stFetch; // Instruction done
                        stHalt: nextState = stHalt; // Left only by reset
                        stTrap: nextState = stTrap;
                        default: nextState = stTrap;
                endcase
        end

        assign status.halted = (state == stHalt) || (state == stTrap);
        assign status.illegal = (state == stTrap);
endmodule

// ==== controlWordTable.sv ====
module controlWordTable import riscvControlPkg::*; (
        input stateT state,
        input logic lessThan, // Compare result from the previous cycle
        output tableWordT ctrl
);
        always_comb begin
                ctrl = idleWord; // Reset, memory read, halt and trap stay idle
                case (state)
                        stFetch: begin
                                ctrl.pcWrite = 1'b1; // PC + 4
                                ctrl.aluSrcA = srcAPc;
                                ctrl.aluSrcB = srcBFour;
                                ctrl.aluFct = aluAdd;
                        end
                        stSaveInstr: ctrl.loadIr = 1'b1;
                        stDecode: begin
                                ctrl.loadRegA = 1'b1; // Latch rs1 and rs2
                                ctrl.loadRegB = 1'b1;
                        end
                        stAluAdd, stAluSub, stAluAnd: begin
                                ctrl.loadAluOut = 1'b1;
                                ctrl.aluSrcA = srcARegA;
                                ctrl.aluSrcB = srcBRegB;
                                ctrl.aluFct = (state == stAluSub) ? aluSub :
                                        (state == stAluAnd) ? aluAnd : aluAdd;
                        end
                        stAluImm, stMemAddr: begin
                                ctrl.loadAluOut = 1'b1; // Result or effective address
                                ctrl.aluSrcA = srcARegA;
                                ctrl.aluSrcB = srcBImm;
                                ctrl.aluFct = aluAdd;
                        end
                        stSetCompare, stSetCompareImm: begin
                                ctrl.aluSrcA = srcARegA;
                                ctrl.aluSrcB = (state == stSetCompareImm) ? srcBImm : srcBRegB;
                                ctrl.aluFct = aluCompare; // Flags only, nothing latched
                        end
                        stSetLess: begin
                                ctrl.loadAluOut = 1'b1; // 0 + 1 or 0 + 0
                                ctrl.aluSrcA = srcAZero;
                                ctrl.aluSrcB = lessThan ? srcBOne : srcBZero;
                                ctrl.aluFct = aluAdd;
                        end
                        stWriteAlu, stLinkWrite: begin
                                ctrl.regWrite = 1'b1; // rd from AluOut
                                ctrl.memToReg = fromAluOut;
                        end
                        stMdrLoad: ctrl.loadMdr = 1'b1;
                        stWriteMem: begin
                                ctrl.regWrite = 1'b1; // rd from MDR
                                ctrl.memToReg = fromMem;
                        end
                        stStore: ctrl.memWrite = 1'b1; // Address in AluOut, data in RegB
                        stBranch: begin
                                ctrl.aluSrcA = srcARegA;
                                ctrl.aluSrcB = srcBRegB;
                                ctrl.aluFct = aluCompare;
                        end
                        stBranchTake, stJumpPc: begin
                                ctrl.pcWrite = 1'b1; // PC + offset
                                ctrl.aluSrcA = srcAPc;
                                ctrl.aluSrcB = srcBImm;
                                ctrl.aluFct = aluAdd;
                        end
                        stLui: begin
                                ctrl.loadAluOut = 1'b1;
                                ctrl.aluSrcA = srcAZero;
                                ctrl.aluSrcB = srcBImm;
                                ctrl.aluFct = aluAdd;
                        end
                        stLinkSave: begin
                                ctrl.loadAluOut = 1'b1; // Return address, PC already + 4
                                ctrl.aluSrcA = srcAPc;
                                ctrl.aluSrcB = srcBZero;
                                ctrl.aluFct = aluAdd;
                        end
                        stJumpReg: begin
                                ctrl.pcWrite = 1'b1; // rs1 + offset
                                ctrl.aluSrcA = srcARegA;
                                ctrl.aluSrcB = srcBImm;
                                ctrl.aluFct = aluAdd;
                        end
                        default: ctrl = idleWord;
                endcase
        end
endmodule

// ==== controlUnit.sv ====
module controlUnit import riscvControlPkg::*; (
        input logic clock,
        input logic reset,
        input logic [instrWidth-1:0] instr,
        input aluFlagsT flags,
        output controlWordT ctrl,
        output unitStatusT status
);
        opKindT opKind;
        immTypeT immType;
        stateT state;
        tableWordT tableWord;

        instrDecoder instrDecoder_inst (
                .instr(instr),
                .opKind(opKind),
                .immType(immType)
        );

        controlSequencer controlSequencer_inst (
                .clock(clock),
                .reset(reset),
                .opKind(opKind),
                .flags(flags),
                .state(state),
                .status(status)
        );

        controlWordTable controlWordTable_inst (
                .state(state),
                .lessThan(flags.lessThan),
                .ctrl(tableWord)
        );

        assign ctrl = {tableWord, immType}; // Immediate format rides in the low bits
endmodule

// ==== controlUnitChk.sv ====
module controlUnitChk import riscvControlPkg::*; (
        input logic clock,
        input logic reset,
        input controlWordT ctrl,
        input unitStatusT status
);
        timeunit 1ns;
        timeprecision 1ps;

        logic anyStrobe;

        assign anyStrobe = ctrl.loadIr || ctrl.pcWrite || ctrl.regWrite || ctrl.loadRegA ||
                ctrl.loadRegB || ctrl.loadMdr || ctrl.loadAluOut || ctrl.memWrite;

        memRegExclusive: assert property (@(posedge clock) disable iff (reset)
                !(ctrl.memWrite && ctrl.regWrite))
                else $error("memWrite and regWrite high in the same cycle");

        // The instruction register loads right after the PC + 4 fetch
        irAfterFetch: assert property (@(posedge clock) disable iff (reset)
                ctrl.loadIr |-> $past(ctrl.pcWrite && ctrl.aluSrcB == srcBFour))
                else $error("loadIr high without a preceding fetch");

        haltedIdle: assert property (@(posedge clock) disable iff (reset)
                status.halted |-> !anyStrobe)
                else $error("Strobe active while halted");
endmodule

bind controlUnit controlUnitChk controlUnitChk_inst (
        .clock(clock),
        .reset(reset),
        .ctrl(ctrl),
        .status(status)
);

// ==== controlUnitTb.sv ====
module controlUnitTb import riscvControlPkg::*; ();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int clockPeriod = 40;
        localparam int driveDelay = 5; // After the rising edge
        localparam int resetCycles = 8;
        localparam int watchdogCycles = 400; // Full run is near 230 cycles
        localparam logic [7:0] sNone = 8'h00; // Strobe order loadIr down to memWrite
        localparam logic [7:0] sLoadIr = 8'h80;
        localparam logic [7:0] sPcWrite = 8'h40;
        localparam logic [7:0] sRegWrite = 8'h20;
        localparam logic [7:0] sRegAB = 8'h18;
        localparam logic [7:0] sMdr = 8'h04;
        localparam logic [7:0] sAluOut = 8'h02;
        localparam logic [7:0] sMemWrite = 8'h01;

        logic clock;
        logic reset;
        logic [instrWidth-1:0] instr;
        aluFlagsT flags;
        controlWordT ctrl;
        unitStatusT status;

        int mismatchCount = 0;
        int otherCount = 0;
        logic [31:0] rngState = 32'd27;
        immTypeT curImm = immI; // Format the current instruction should report
        controlWordT expQ[$]; // Words after decode

        controlUnit controlUnit_inst (
                .clock(clock),
                .reset(reset),
                .instr(instr),
                .flags(flags),
                .ctrl(ctrl),
                .status(status)
        );

        initial begin
                clock = 1'b0;
                forever #(clockPeriod / 2) clock = ~clock;
        end

        initial begin
                repeat (watchdogCycles) @(posedge clock);
                $display("Timeout: the run did not end within %0d cycles", watchdogCycles);
                $display("TESTBENCH FAILED");
                $finish;
        end

        function automatic logic [31:0] xorshiftNext();
                logic [31:0] x;
                x = rngState;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                rngState = x;
                return x;
        endfunction

        function automatic controlWordT makeWord(input logic [7:0] strobes, input memToRegT m2r,
                        input aluSrcAT srcA, input aluSrcBT srcB, input aluFctT fct);
                controlWordT w;
                {w.loadIr, w.pcWrite, w.regWrite, w.loadRegA, w.loadRegB, w.loadMdr,
                        w.loadAluOut, w.memWrite} = strobes;
                w.memToReg = m2r;
                w.aluSrcA = srcA;
                w.aluSrcB = srcB;
                w.aluFct = fct;
                w.immType = curImm;
                return w;
        endfunction

        function automatic controlWordT writeAluWord();
                return makeWord(sRegWrite, fromAluOut, srcAPc, srcBRegB, aluAdd);
        endfunction

        function automatic logic [7:0] strobesOf(input controlWordT w);
                return {w.loadIr, w.pcWrite, w.regWrite, w.loadRegA, w.loadRegB, w.loadMdr,
                        w.loadAluOut, w.memWrite};
        endfunction

        // RISC-V branch conditions
        function automatic logic branchTaken(input logic [2:0] f3, input aluFlagsT fl);
                case (f3)
                        f3Beq: return fl.equal;
                        f3Bne: return !fl.equal;
                        f3Blt: return fl.lessThan;
                        f3Bge: return !fl.lessThan;
                        default: return 1'b0;
                endcase
        endfunction

        task automatic compareNow(input string name, input int idx, input controlWordT exp,
                        input unitStatusT expStatus);
                if (ctrl !== exp) begin
                        mismatchCount++;
                        $display("Mismatch ctrl in %s cycle %0d: got %h, expected %h",
                                name, idx, ctrl, exp);
                end
                if (status !== expStatus) begin
                        mismatchCount++;
                        $display("Mismatch status in %s cycle %0d: got %h, expected %h",
                                name, idx, status, expStatus);
                end
        endtask

        task automatic checkIdle(input string when);
                if (strobesOf(ctrl) !== sNone || status !== 2'b00) begin
                        mismatchCount++;
                        $display("Mismatch strobes/status %s: got %h/%h, expected 00/0",
                                when, strobesOf(ctrl), status);
                end
        endtask

        task automatic applyReset();
                @(posedge clock);
                #driveDelay;
                reset = 1'b1;
                repeat (resetCycles) begin
                        @(negedge clock);
                        checkIdle("during reset");
                end
                @(posedge clock);
                #driveDelay;
                reset = 1'b0;
                @(negedge clock); // First cycle after reset, still in stReset
                checkIdle("after reset");
        endtask

        // Drives one instruction from its fetch cycle and walks the expected words
        task automatic runInstr(input string name, input logic [31:0] word, input aluFlagsT fl,
                        input unitStatusT bodyStatus);
                int waited;
                @(posedge clock);
                #driveDelay;
                instr = word;
                flags = fl;
                @(negedge clock);
                waited = 0;
                while (!(ctrl.pcWrite && ctrl.aluSrcB == srcBFour) && waited < 10) begin
                        @(negedge clock);
                        waited++;
                end
                if (waited != 0) begin
                        otherCount++;
                        $display("Fetch for %s did not come on time, waited %0d cycles",
                                name, waited);
                end
                compareNow(name, 0, makeWord(sPcWrite, fromMem, srcAPc, srcBFour, aluAdd), 2'b00);
                @(negedge clock);
                compareNow(name, 1, makeWord(sLoadIr, fromMem, srcAPc, srcBRegB, aluAdd), 2'b00);
                @(negedge clock);
                compareNow(name, 2, makeWord(sRegAB, fromMem, srcAPc, srcBRegB, aluAdd), 2'b00);
                foreach (expQ[i]) begin
                        @(negedge clock);
                        compareNow(name, i + 3, expQ[i], bodyStatus);
                end
                expQ.delete();
        endtask

        task automatic registerAluOps();
                logic [31:0] r;
                curImm = immI;
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcARegA, srcBRegB, aluAdd));
                expQ.push_back(writeAluWord());
                runInstr("add", {f7Base, r[24:15], f3Add, r[11:7], opR}, r[1:0], 2'b00);
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcARegA, srcBRegB, aluSub));
                expQ.push_back(writeAluWord());
                runInstr("sub", {f7Sub, r[24:15], f3Add, r[11:7], opR}, r[1:0], 2'b00);
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcARegA, srcBRegB, aluAnd));
                expQ.push_back(writeAluWord());
                runInstr("and", {f7Base, r[24:15], f3And, r[11:7], opR}, r[1:0], 2'b00);
        endtask

        task automatic immediateOps();
                logic [31:0] r;
                curImm = immI;
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcARegA, srcBImm, aluAdd));
                expQ.push_back(writeAluWord());
                // rd forced odd so the word can never be the canonical nop
                runInstr("addi", {r[31:20], r[19:15], f3Addi, r[11:8], 1'b1, opImm}, 2'b00, 2'b00);
                curImm = immU;
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcAZero, srcBImm, aluAdd));
                expQ.push_back(writeAluWord());
                runInstr("lui", {r[31:12], r[11:7], opLui}, r[1:0], 2'b00);
        endtask

        task automatic setLessThanOps();
                logic [31:0] r;
                aluFlagsT fl;
                curImm = immI;
                for (int lt = 0; lt < 2; lt++) begin
                        r = xorshiftNext();
                        fl.equal = r[0];
                        fl.lessThan = lt[0];
                        expQ.push_back(makeWord(sNone, fromMem, srcARegA, srcBRegB, aluCompare));
                        expQ.push_back(makeWord(sAluOut, fromMem, srcAZero,
                                lt ? srcBOne : srcBZero, aluAdd));
                        expQ.push_back(writeAluWord());
                        runInstr("slt", {f7Base, r[24:15], f3Slt, r[11:7], opR}, fl, 2'b00);
                        expQ.push_back(makeWord(sNone, fromMem, srcARegA, srcBImm, aluCompare));
                        expQ.push_back(makeWord(sAluOut, fromMem, srcAZero,
                                lt ? srcBOne : srcBZero, aluAdd));
                        expQ.push_back(writeAluWord());
                        runInstr("slti", {r[31:20], r[19:15], f3Slti, r[11:7], opImm}, fl, 2'b00);
                end
        endtask

        task automatic loadStoreOps();
                logic [31:0] r;
                curImm = immI;
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcARegA, srcBImm, aluAdd));
                expQ.push_back(makeWord(sNone, fromMem, srcAPc, srcBRegB, aluAdd)); // Read
                expQ.push_back(makeWord(sMdr, fromMem, srcAPc, srcBRegB, aluAdd));
                expQ.push_back(makeWord(sRegWrite, fromMem, srcAPc, srcBRegB, aluAdd));
                runInstr("ld", {r[31:20], r[19:15], f3Ld, r[11:7], opLoad}, r[1:0], 2'b00);
                curImm = immS;
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcARegA, srcBImm, aluAdd));
                expQ.push_back(makeWord(sMemWrite, fromMem, srcAPc, srcBRegB, aluAdd));
                runInstr("sd", {r[31:25], r[24:15], f3Sd, r[11:7], opStore}, r[1:0], 2'b00);
        endtask

        // Every branch against all four flag combinations
        task automatic branchOps();
                logic [2:0] codes [4] = '{f3Beq, f3Bne, f3Blt, f3Bge};
                logic [31:0] r;
                aluFlagsT fl;
                curImm = immSb;
                for (int i = 0; i < 4; i++) begin
                        for (int f = 0; f < 4; f++) begin
                                r = xorshiftNext();
                                fl = f[1:0];
                                expQ.push_back(makeWord(sNone, fromMem, srcARegA, srcBRegB,
                                        aluCompare));
                                if (branchTaken(codes[i], fl)) begin
                                        expQ.push_back(makeWord(sPcWrite, fromMem, srcAPc,
                                                srcBImm, aluAdd));
                                end
                                runInstr($sformatf("branch f3=%0d flags=%b", codes[i], fl),
                                        {r[31:25], r[24:15], codes[i], r[11:7], opBranch}, fl,
                                        2'b00);
                        end
                end
        endtask

        task automatic jumpAndNopOps();
                logic [31:0] r;
                curImm = immUj;
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcAPc, srcBZero, aluAdd));
                expQ.push_back(writeAluWord());
                expQ.push_back(makeWord(sPcWrite, fromMem, srcAPc, srcBImm, aluAdd));
                runInstr("jal", {r[31:12], r[11:7], opJal}, r[1:0], 2'b00);
                curImm = immI;
                r = xorshiftNext();
                expQ.push_back(makeWord(sAluOut, fromMem, srcAPc, srcBZero, aluAdd));
                expQ.push_back(writeAluWord());
                expQ.push_back(makeWord(sPcWrite, fromMem, srcARegA, srcBImm, aluAdd));
                runInstr("jalr", {r[31:20], r[19:15], f3Jalr, r[11:7], opJalr}, r[1:0], 2'b00);
                runInstr("nop", nopWord, 2'b00, 2'b00); // Straight back to fetch
        endtask

        // Ten idle cycles with the status held, then reset brings the unit back
        task automatic haltCase(input string name, input logic [31:0] word, input logic illegal);
                curImm = immI;
                repeat (10) expQ.push_back(makeWord(sNone, fromMem, srcAPc, srcBRegB, aluAdd));
                runInstr(name, word, 2'b00, {1'b1, illegal});
                applyReset();
        endtask

        task automatic haltAndTrap();
                logic [31:0] r;
                r = xorshiftNext();
                haltCase("break", {12'h001, 5'd0, f3Break, 5'd0, opSystem}, 1'b0);
                haltCase("unknown opcode", {r[31:7], 7'b1111111}, 1'b1);
                haltCase("unknown funct7", {7'b0000001, r[24:15], f3Add, r[11:7], opR}, 1'b1);
        endtask

        initial begin
                reset = 1'b1;
                instr = nopWord;
                flags = 2'b00;
                applyReset();
                registerAluOps();
                immediateOps();
                setLessThanOps();
                loadStoreOps();
                branchOps();
                jumpAndNopOps();
                haltAndTrap();
                $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
                if (mismatchCount == 0 && otherCount == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end
endmodule

// ==== project.f ====
riscvControlPkg.sv
instrDecoder.sv
controlSequencer.sv
controlWordTable.sv
controlUnit.sv
controlUnitChk.sv
controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module controlUnitTb \
        -f project.f -o controlUnitSim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/controlUnitSim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
